// File: verif/fpga_core_trace.txt
# columns: name op bar addr first_be data exp_status exp_data (all numbers hex)
# ops are cfg, wr and rd; cfg puts the bus/device number in the data column
ur_before_cfg   rd  1 00000010 f 00000000 1 00000000
cfg_busdev      cfg 0 00000000 0 00000a5b 0 00000000
wr_a            wr  0 00000000 f 11223344 0 00000000
wr_b            wr  0 00000004 f a5a5a5a5 0 00000000
wr_c            wr  0 00000008 f deadbeef 0 00000000
rd_a            rd  0 00000000 f 00000000 0 11223344
wr_merge        wr  0 00000004 5 00ff00ff 0 00000000
rd_merge        rd  0 00000004 f 00000000 0 a5ffa5ff
wr_alias        wr  0 00000108 3 0000cafe 0 00000000
rd_alias        rd  0 00000008 f 00000000 0 deadcafe
rd_alias_hi     rd  0 00000f08 f 00000000 0 deadcafe
wr_other        wr  2 00000000 f 99999999 0 00000000
rd_other        rd  2 00000000 f 00000000 1 00000000
rd_after_other  rd  0 00000000 f 00000000 0 11223344
wr_d            wr  0 0000007c f 0badf00d 0 00000000
wr_hi_be        wr  0 0000007c 8 77000000 0 00000000
rd_d            rd  0 0000017c f 00000000 0 77adf00d
cfg_busdev2     cfg 0 00000000 0 00001fff 0 00000000
rd_burst_0      rd  0 00000000 f 00000000 0 11223344
rd_burst_1      rd  0 00000004 f 00000000 0 a5ffa5ff
rd_burst_2      rd  0 00000008 f 00000000 0 deadcafe
rd_burst_ur     rd  5 00000044 f 00000000 1 00000000
rd_burst_3      rd  0 0000007c f 00000000 0 77adf00d

// File: filelist.f
hdl/pcie_core_pkg.sv
hdl/rx_tlp_parser.sv
hdl/bar_mem_engine.sv
hdl/tx_cpl_builder.sv
hdl/fpga_core.sv
verif/fpga_core_chk.sv
verif/fpga_core_monitor.sv
verif/tb_fpga_core.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_fpga_core
FILELIST = filelist.f
OBJ_DIR  = obj_dir

BIN  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: verif/tb_fpga_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_core;

    localparam int          BAR0_APERTURE = 8;
    localparam int unsigned SEED          = 32'h4ec8_a943;

    logic        clk;
    logic        reset;
    logic [31:0] rx_st_data;
    logic        rx_st_sop;
    logic        rx_st_eop;
    logic        rx_st_valid;
    wire         rx_st_ready;
    logic [2:0]  rx_st_bar_range;
    wire  [31:0] tx_st_data;
    wire         tx_st_sop;
    wire         tx_st_eop;
    wire         tx_st_valid;
    logic        tx_st_ready;
    logic [31:0] tl_cfg_ctl;
    logic [4:0]  tl_cfg_add;

    int          cpl_count;
    int          mon_errors;
    int          tb_errors;
    int          reads_sent;
    int          line_count;
    logic        trace_loaded;
    logic [31:0] t_op [$];   // trace operations in file order.
    logic [31:0] t_bar [$];
    logic [31:0] t_addr [$];
    logic [31:0] t_be [$];
    logic [31:0] t_data [$];

    fpga_core #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) uut (
        .clk(clk),
        .reset(reset),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_ready(rx_st_ready),
        .rx_st_bar_range(rx_st_bar_range),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready),
        .tl_cfg_ctl(tl_cfg_ctl),
        .tl_cfg_add(tl_cfg_add)
    );

    fpga_core_monitor #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) monitor_inst (
        .clk(clk),
        .reset(reset),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready),
        .cpl_count(cpl_count),
        .errors(mon_errors)
    );

    always #2 clk = ~clk; // 4 ns period.

    // about one beat in four is refused on tx_st.
    initial begin
        void'($urandom(SEED));
        forever begin
            @(posedge clk);
            #1;
            tx_st_ready = ($urandom % 4) != 0;
        end
    end

    // called 1 ns after an edge and returns 1 ns after the edge that took the beat.
    task automatic send_beat(input logic [31:0] d, input logic sop, input logic eop,
                             input logic [2:0] bar);
        rx_st_data      = d;
        rx_st_sop       = sop;
        rx_st_eop       = eop;
        rx_st_bar_range = bar;
        rx_st_valid     = 1'b1;
        while (!rx_st_ready) begin
            @(posedge clk);
            #1;
        end
        @(posedge clk);
        #1;
    endtask

    // one 3-dword-header memory request; the requester id and tag come from the line index.
    task automatic send_request(input int idx, input logic is_write, input logic [2:0] bar,
                                input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] data);
        logic [31:0] dw0;
        logic [31:0] dw1;
        dw0 = is_write ? 32'h4000_0001 : 32'h0000_0001; // MWr32 or MRd32, length 1.
        dw1 = {8'hb0, idx[7:0], idx[7:0] ^ 8'h5a, 4'h0, be};
        send_beat(dw0, 1'b1, 1'b0, bar);
        send_beat(dw1, 1'b0, 1'b0, bar);
        send_beat(addr, 1'b0, !is_write, bar);
        if (is_write) send_beat(data, 1'b0, 1'b1, bar);
        rx_st_valid = 1'b0;
        rx_st_sop   = 1'b0;
        rx_st_eop   = 1'b0;
    endtask

    task automatic load_trace();
        int            fd;
        int            n;
        logic [1023:0] line;
        logic [127:0]  name;
        logic [31:0]   op;
        logic [31:0]   bar;
        logic [31:0]   addr;
        logic [31:0]   be;
        logic [31:0]   data;
        logic [31:0]   status;
        logic [31:0]   expect_data;
        fd = $fopen("verif/fpga_core_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            tb_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) == 0) break;
                n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, bar, addr, be, data,
                            status, expect_data);
                if (n != 8) continue; // comments carry no operation.
                t_op.push_back(op);
                t_bar.push_back(bar);
                t_addr.push_back(addr);
                t_be.push_back(be);
                t_data.push_back(data);
            end
            $fclose(fd);
        end
        line_count = t_op.size();
    endtask

    // the budget scales with the trace so a stuck handshake ends the run.
    initial begin
        wait (trace_loaded);
        repeat (200 * (line_count + 1)) @(posedge clk);
        $display("timeout: no progress after %0d cycles", 200 * (line_count + 1));
        $display("errors: %0d mismatch, %0d other", mon_errors, tb_errors + 1);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        reset           = 1'b1;
        rx_st_data      = 32'd0;
        rx_st_sop       = 1'b0;
        rx_st_eop       = 1'b0;
        rx_st_valid     = 1'b0;
        rx_st_bar_range = 3'd0;
        tx_st_ready     = 1'b0;
        tl_cfg_ctl      = 32'd0;
        tl_cfg_add      = 5'd0;
        tb_errors       = 0;
        reads_sent      = 0;
        line_count      = 0;
        trace_loaded    = 1'b0;
        load_trace();
        trace_loaded = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int i = 0; i < line_count; i++) begin
            if (t_op[i] == "cfg") begin
                wait (cpl_count == reads_sent); // older reads keep the old completer id.
                @(posedge clk);
                #1;
                tl_cfg_add = 5'h0f; // bus/device index of the configuration bus.
                tl_cfg_ctl = t_data[i];
                @(posedge clk);
                #1;
                tl_cfg_add = 5'd0;
                tl_cfg_ctl = 32'd0;
            end else if (t_op[i] == "wr" || t_op[i] == "rd") begin
                send_request(i, t_op[i] == "wr", t_bar[i][2:0], t_addr[i], t_be[i][3:0],
                             t_data[i]);
                if (t_op[i] == "rd") reads_sent++;
            end else begin
                $display("trace line %0d has an unknown operation", i);
                tb_errors++;
            end
        end
        wait (cpl_count >= reads_sent);
        repeat (10) @(posedge clk); // lets a stray extra completion show up.
        $display("errors: %0d mismatch, %0d other", mon_errors, tb_errors);
        if (mon_errors == 0 && tb_errors == 0 && cpl_count == reads_sent) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/fpga_core_monitor.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_core_monitor #(
    parameter int BAR0_APERTURE = 8
) (
    input  wire        clk,
    input  wire        reset,
    input  wire [31:0] tx_st_data,
    input  wire        tx_st_sop,
    input  wire        tx_st_eop,
    input  wire        tx_st_valid,
    input  wire        tx_st_ready,
    output int         cpl_count,  // completions seen on tx_st.
    output int         errors      // mismatches and protocol faults.
);

    logic [127:0] exp_name [$]; // expected completions in request order.
    logic [31:0]  exp_dw0 [$];
    logic [31:0]  exp_dw1 [$];
    logic [31:0]  exp_dw2 [$];
    logic [31:0]  exp_data [$];
    logic         exp_has_data [$];
    logic [31:0]  model [int];  // BAR0 contents keyed by dword index.
    logic [31:0]  beats [4];
    int           nbeats;

    // compares one field and logs it under the trace name of the read.
    task automatic check_field(input logic [127:0] name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %0s expected %08h actual %08h", name, expected, actual);
            errors++;
        end
    endtask

    // the trace is replayed against a reference model to build every expected completion.
    initial begin
        int           fd;
        int           n;
        int           idx;
        int           word;
        logic [1023:0] line;
        logic [127:0] name;
        logic [31:0]  op;
        logic [31:0]  bar;
        logic [31:0]  addr;
        logic [31:0]  be;
        logic [31:0]  data;
        logic [31:0]  status;
        logic [31:0]  expect_data;
        logic [15:0]  cid;
        logic [2:0]   st;
        logic [31:0]  rd_val;
        errors    = 0;
        cpl_count = 0;
        nbeats    = 0;
        idx       = 0;
        cid       = 16'h0000; // completer id is zero until configured.
        fd = $fopen("verif/fpga_core_trace.txt", "r");
        if (fd == 0) begin
            $display("monitor could not open the trace file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = '0;
                if ($fgets(line, fd) == 0) break;
                n = $sscanf(line, "%s %s %h %h %h %h %h %h", name, op, bar, addr, be, data,
                            status, expect_data);
                if (n != 8) continue; // comments and blank lines.
                word = int'((addr >> 2) & ((32'd1 << (BAR0_APERTURE - 2)) - 32'd1));
                if (op == "cfg") begin
                    cid = {data[12:0], 3'b000}; // function number is always zero.
                end else if (op == "wr" && bar == 0) begin
                    if (!model.exists(word)) model[word] = 32'd0;
                    for (int i = 0; i < 4; i++) begin
                        if (be[i]) model[word][8*i +: 8] = data[8*i +: 8];
                    end
                end else if (op == "rd") begin
                    st     = (bar == 0) ? 3'b000 : 3'b001; // SC on BAR0, UR elsewhere.
                    rd_val = (bar == 0 && model.exists(word)) ? model[word] : 32'd0;
                    if (status[2:0] != st || expect_data != rd_val) begin
                        $display("mismatch %0s expected %08h actual %08h (trace column)",
                                 name, rd_val, expect_data);
                        errors++;
                    end
                    exp_name.push_back(name);
                    exp_dw0.push_back(st == 3'b000 ? 32'h4a00_0001 : 32'h0a00_0000);
                    exp_dw1.push_back({cid, st, 1'b0, 12'd4});
                    exp_dw2.push_back({8'hb0, idx[7:0], idx[7:0] ^ 8'h5a, 1'b0, addr[6:0]});
                    exp_data.push_back(rd_val);
                    exp_has_data.push_back(st == 3'b000);
                end
                idx++;
            end
            $fclose(fd);
        end
    end

    // beats are sampled at the edge where valid and ready are both high.
    always @(posedge clk) begin
        if (!reset && tx_st_valid && tx_st_ready) begin
            if (tx_st_sop != (nbeats == 0)) begin
                $display("tx_st_sop was %0b on beat %0d of a completion", tx_st_sop, nbeats);
                errors++;
            end
            if (nbeats < 4) beats[nbeats] = tx_st_data;
            nbeats++;
            if (tx_st_eop) begin
                cpl_count++;
                if (exp_name.size() == 0) begin
                    $display("unexpected completion with no read outstanding");
                    errors++;
                end else begin
                    check_field(exp_name[0], exp_has_data[0] ? 32'd4 : 32'd3, nbeats);
                    check_field(exp_name[0], exp_dw0[0], beats[0]); // fmt, type, length.
                    check_field(exp_name[0], exp_dw1[0], beats[1]); // completer, status.
                    check_field(exp_name[0], exp_dw2[0], beats[2]); // requester, tag.
                    if (exp_has_data[0] && nbeats == 4) begin
                        check_field(exp_name[0], exp_data[0], beats[3]);
                    end
                    void'(exp_name.pop_front());
                    void'(exp_dw0.pop_front());
                    void'(exp_dw1.pop_front());
                    void'(exp_dw2.pop_front());
                    void'(exp_data.pop_front());
                    void'(exp_has_data.pop_front());
                end
                nbeats = 0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/fpga_core_chk.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_core_chk (
    input wire        clk,
    input wire        reset,
    input wire [31:0] tx_st_data,
    input wire        tx_st_sop,
    input wire        tx_st_eop,
    input wire        tx_st_valid,
    input wire        tx_st_ready
);

    logic in_pkt; // a completion has started on tx_st and its eop has not passed yet.

    always_ff @(posedge clk) begin
        if (reset) begin
            in_pkt <= 1'b0;
        end else if (tx_st_valid && tx_st_ready) begin
            in_pkt <= !tx_st_eop; // the eop beat closes the TLP.
        end
    end

    // a stalled beat keeps its data and framing until it is taken.
    hold_until_ready: assert property (@(posedge clk) disable iff (reset)
        tx_st_valid && !tx_st_ready |=> tx_st_valid && $stable(tx_st_data) &&
                                        $stable(tx_st_sop) && $stable(tx_st_eop))
        else $error("tx_st beat changed or vanished before tx_st_ready");

    sop_opens_tlp: assert property (@(posedge clk) disable iff (reset)
        tx_st_valid && !in_pkt |-> tx_st_sop)
        else $error("tx_st TLP started without sop");

    no_sop_inside: assert property (@(posedge clk) disable iff (reset)
        tx_st_valid && in_pkt |-> !tx_st_sop)
        else $error("tx_st sop seen inside an unfinished TLP");

    // the first reset edge may still see power-up values, so the check starts one cycle in.
    quiet_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> !tx_st_valid)
        else $error("tx_st_valid high during reset");

endmodule

bind fpga_core fpga_core_chk chk_inst (
    .clk(clk),
    .reset(reset),
    .tx_st_data(tx_st_data),
    .tx_st_sop(tx_st_sop),
    .tx_st_eop(tx_st_eop),
    .tx_st_valid(tx_st_valid),
    .tx_st_ready(tx_st_ready)
);

`default_nettype wire

// File: hdl/fpga_core.sv
`timescale 1ns/1ps
`default_nettype none

module fpga_core #(
    parameter int BAR0_APERTURE = 8
) (
    input  wire        clk,
    input  wire        reset,
    input  wire [31:0] rx_st_data,
    input  wire        rx_st_sop,
    input  wire        rx_st_eop,
    input  wire        rx_st_valid,
    output wire        rx_st_ready,
    input  wire [2:0]  rx_st_bar_range,
    output wire [31:0] tx_st_data,
    output wire        tx_st_sop,
    output wire        tx_st_eop,
    output wire        tx_st_valid,
    input  wire        tx_st_ready,
    input  wire [31:0] tl_cfg_ctl,
    input  wire [4:0]  tl_cfg_add
);

    // decoded requests from the parser into the engine.
    wire        req_valid;
    wire        req_ready;
    wire        req_write;
    wire        req_bar0;
    wire [31:0] req_addr;
    wire [3:0]  req_first_be;
    wire [31:0] req_wdata;
    wire [15:0] req_requester_id;
    wire [7:0]  req_tag;

    // read results from the engine into the completion builder.
    wire        cpl_valid;
    wire        cpl_ready;
    wire [2:0]  cpl_status;
    wire [31:0] cpl_data;
    wire [15:0] cpl_requester_id;
    wire [7:0]  cpl_tag;
    wire [6:0]  cpl_lower_addr;

    rx_tlp_parser rx_tlp_parser_inst (
        .clk(clk),
        .reset(reset),
        .rx_st_data(rx_st_data),
        .rx_st_sop(rx_st_sop),
        .rx_st_eop(rx_st_eop),
        .rx_st_valid(rx_st_valid),
        .rx_st_bar_range(rx_st_bar_range),
        .rx_st_ready(rx_st_ready),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_write(req_write),
        .req_bar0(req_bar0),
        .req_addr(req_addr),
        .req_first_be(req_first_be),
        .req_wdata(req_wdata),
        .req_requester_id(req_requester_id),
        .req_tag(req_tag)
    );

    bar_mem_engine #(
        .BAR0_APERTURE(BAR0_APERTURE)
    ) bar_mem_engine_inst (
        .clk(clk),
        .reset(reset),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_write(req_write),
        .req_bar0(req_bar0),
        .req_addr(req_addr),
        .req_first_be(req_first_be),
        .req_wdata(req_wdata),
        .req_requester_id(req_requester_id),
        .req_tag(req_tag),
        .cpl_valid(cpl_valid),
        .cpl_ready(cpl_ready),
        .cpl_status(cpl_status),
        .cpl_data(cpl_data),
        .cpl_requester_id(cpl_requester_id),
        .cpl_tag(cpl_tag),
        .cpl_lower_addr(cpl_lower_addr)
    );

    tx_cpl_builder tx_cpl_builder_inst (
        .clk(clk),
        .reset(reset),
        .cpl_valid(cpl_valid),
        .cpl_ready(cpl_ready),
        .cpl_status(cpl_status),
        .cpl_data(cpl_data),
        .cpl_requester_id(cpl_requester_id),
        .cpl_tag(cpl_tag),
        .cpl_lower_addr(cpl_lower_addr),
        .tl_cfg_ctl(tl_cfg_ctl),
        .tl_cfg_add(tl_cfg_add),
        .tx_st_data(tx_st_data),
        .tx_st_sop(tx_st_sop),
        .tx_st_eop(tx_st_eop),
        .tx_st_valid(tx_st_valid),
        .tx_st_ready(tx_st_ready)
    );

endmodule

`default_nettype wire

// File: hdl/tx_cpl_builder.sv
`timescale 1ns/1ps
`default_nettype none

module tx_cpl_builder (
    input  wire         clk,
    input  wire         reset,
    input  wire         cpl_valid,
    output wire         cpl_ready,
    input  wire  [2:0]  cpl_status,
    input  wire  [31:0] cpl_data,
    input  wire  [15:0] cpl_requester_id,
    input  wire  [7:0]  cpl_tag,
    input  wire  [6:0]  cpl_lower_addr,
    input  wire  [31:0] tl_cfg_ctl,
    input  wire  [4:0]  tl_cfg_add,
    output logic [31:0] tx_st_data,
    output wire         tx_st_sop,
    output wire         tx_st_eop,
    output wire         tx_st_valid,
    input  wire         tx_st_ready
);

    logic [12:0] bus_dev;   // captured {bus, device} from the configuration bus.
    logic        busy;      // a completion is being shifted out.
    logic [1:0]  beat_cnt;  // beat on tx_st right now.
    logic        with_data; // CplD carries a fourth beat.
    logic [31:0] hdr_dw0;
    logic [31:0] hdr_dw1;
    logic [31:0] hdr_dw2;
    logic [31:0] pay_dw3;
    logic        cpl_sc;
    logic        cpl_fire;
    logic        beat_fire;
    pcie_core_pkg::tlp_dw1_u dw1_next;

    assign cpl_ready = !busy; // one completion at a time.
    assign cpl_fire  = cpl_valid && cpl_ready;
    assign beat_fire = tx_st_valid && tx_st_ready;
    assign cpl_sc    = cpl_status == pcie_core_pkg::CPL_SC;

    assign tx_st_valid = busy;
    assign tx_st_sop   = busy && beat_cnt == 2'd0;
    assign tx_st_eop   = busy && beat_cnt == (with_data ? 2'd3 : 2'd2);

    // completion view of dw1, function number fixed at zero.
    always_comb begin
        dw1_next                  = '0;
        dw1_next.cpl.completer_id = {bus_dev, 3'b000};
        dw1_next.cpl.status       = cpl_status;
        dw1_next.cpl.bcm          = 1'b0;
        dw1_next.cpl.byte_count   = 12'd4; // always a single full dword.
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bus_dev <= 13'd0;
        end else if (tl_cfg_add == pcie_core_pkg::CFG_ADDR_BUSDEV) begin
            bus_dev <= tl_cfg_ctl[12:0];
        end
    end

    // the whole TLP is formed on acceptance and then only muxed out.
    always_ff @(posedge clk) begin
        if (cpl_fire) begin
            hdr_dw0   <= {1'b0, cpl_sc ? pcie_core_pkg::TLP_CPLD : pcie_core_pkg::TLP_CPL,
                          14'd0, cpl_sc ? 10'd1 : 10'd0}; // UR carries no payload.
            hdr_dw1   <= dw1_next;
            hdr_dw2   <= {cpl_requester_id, cpl_tag, 1'b0, cpl_lower_addr};
            pay_dw3   <= cpl_data;
            with_data <= cpl_sc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= 1'b0;
            beat_cnt <= 2'd0;
        end else if (cpl_fire) begin
            busy     <= 1'b1; // sop is offered on the next cycle.
            beat_cnt <= 2'd0;
        end else if (beat_fire) begin
            if (tx_st_eop) begin
                busy     <= 1'b0;
                beat_cnt <= 2'd0;
            end else begin
                beat_cnt <= beat_cnt + 2'd1;
            end
        end
    end

    always_comb begin
        case (beat_cnt)
            2'd0:    tx_st_data = hdr_dw0;
            2'd1:    tx_st_data = hdr_dw1;
            2'd2:    tx_st_data = hdr_dw2;
            default: tx_st_data = pay_dw3;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/bar_mem_engine.sv
`timescale 1ns/1ps
`default_nettype none

module bar_mem_engine #(
    parameter int BAR0_APERTURE = 8
) (
    input  wire         clk,
    input  wire         reset,
    input  wire         req_valid,
    output wire         req_ready,
    input  wire         req_write,
    input  wire         req_bar0,
    input  wire  [31:0] req_addr,
    input  wire  [3:0]  req_first_be,
    input  wire  [31:0] req_wdata,
    input  wire  [15:0] req_requester_id,
    input  wire  [7:0]  req_tag,
    output logic        cpl_valid,
    input  wire         cpl_ready,
    output logic [2:0]  cpl_status,
    output logic [31:0] cpl_data,
    output logic [15:0] cpl_requester_id,
    output logic [7:0]  cpl_tag,
    output logic [6:0]  cpl_lower_addr
);

    localparam int WORD_AW = BAR0_APERTURE - 2; // dword address width.
    localparam int WORDS   = 2 ** WORD_AW;

    logic [31:0]        mem [WORDS];
    logic [WORD_AW-1:0] word_idx;
    logic               req_fire;
    logic               wr_fire;
    logic               rd_fire;

    assign word_idx = req_addr[BAR0_APERTURE-1:2]; // upper bits alias onto the aperture.

    // writes produce no completion, so they may pass a stalled completion register.
    assign req_ready = req_write || !cpl_valid || cpl_ready;
    assign req_fire  = req_valid && req_ready;
    assign wr_fire   = req_fire && req_write && req_bar0; // other BARs are dropped.
    assign rd_fire   = req_fire && !req_write;

    // byte-lane merge under first_be.
    always_ff @(posedge clk) begin
        if (wr_fire) begin
            for (int i = 0; i < 4; i++) begin
                if (req_first_be[i]) begin
                    mem[word_idx][8*i +: 8] <= req_wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            cpl_valid <= 1'b0;
        end else if (rd_fire) begin
            cpl_valid <= 1'b1; // valid the cycle after the read is taken.
        end else if (cpl_ready) begin
            cpl_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            cpl_status       <= req_bar0 ? pcie_core_pkg::CPL_SC : pcie_core_pkg::CPL_UR;
            cpl_data         <= req_bar0 ? mem[word_idx] : 32'd0;
            cpl_requester_id <= req_requester_id;
            cpl_tag          <= req_tag;
            cpl_lower_addr   <= req_addr[6:0]; // bits 1:0 are zero in a dword address.
        end
    end

endmodule

`default_nettype wire

// File: hdl/rx_tlp_parser.sv
`timescale 1ns/1ps
`default_nettype none

module rx_tlp_parser (
    input  wire         clk,
    input  wire         reset,
    input  wire  [31:0] rx_st_data,
    input  wire         rx_st_sop,
    input  wire         rx_st_eop,
    input  wire         rx_st_valid,
    input  wire  [2:0]  rx_st_bar_range,
    output wire         rx_st_ready,
    output logic        req_valid,
    input  wire         req_ready,
    output logic        req_write,
    output logic        req_bar0,
    output logic [31:0] req_addr,
    output logic [3:0]  req_first_be,
    output logic [31:0] req_wdata,
    output logic [15:0] req_requester_id,
    output logic [7:0]  req_tag
);

    logic [1:0]  beat_cnt;         // index of the next beat within the current TLP.
    logic [1:0]  beat_idx;         // index of the beat on the bus right now.
    logic        beat_fire;
    logic        req_load;         // the last beat of a kept request is accepted.
    logic        cur_keep;         // current TLP is an MRd32 or MWr32.
    logic        cur_write;
    logic        cur_bar0;
    logic [15:0] cur_requester_id;
    logic [7:0]  cur_tag;
    logic [3:0]  cur_first_be;
    logic [31:0] cur_addr;
    pcie_core_pkg::tlp_dw1_u dw1;  // request view of the beat when it is dw1.

    assign beat_fire = rx_st_valid && rx_st_ready;
    assign beat_idx  = rx_st_sop ? 2'd0 : beat_cnt; // sop always restarts the count.
    assign dw1       = rx_st_data;

    // hold dw2 while the finished request still waits, or it would have nowhere to go.
    assign rx_st_ready = !(req_valid && !req_ready && cur_keep && beat_cnt == 2'd2);

    // a read ends on dw2 and a write on dw3. Anything else is malformed and dropped.
    assign req_load = beat_fire && rx_st_eop && cur_keep &&
                      (beat_idx == (cur_write ? 2'd3 : 2'd2));

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_cnt <= 2'd0;
            cur_keep <= 1'b0;
        end else if (beat_fire) begin
            if (rx_st_eop) begin
                beat_cnt <= 2'd0;
            end else if (beat_idx != 2'd3) begin
                beat_cnt <= beat_idx + 2'd1;
            end else begin
                beat_cnt <= 2'd3; // long discarded TLPs park on the last index.
            end
            if (beat_idx == 2'd0) begin
                cur_keep <= rx_st_data[30:24] == pcie_core_pkg::TLP_MRD32 ||
                            rx_st_data[30:24] == pcie_core_pkg::TLP_MWR32;
            end
        end
    end

    // header fields of the TLP in progress.
    always_ff @(posedge clk) begin
        if (beat_fire) begin
            case (beat_idx)
                2'd0: begin
                    cur_write <= rx_st_data[30:24] == pcie_core_pkg::TLP_MWR32;
                    cur_bar0  <= rx_st_bar_range == 3'd0; // bar range is valid on sop.
                end
                2'd1: begin
                    cur_requester_id <= dw1.req.requester_id;
                    cur_tag          <= dw1.req.tag;
                    cur_first_be     <= dw1.req.first_be;
                end
                2'd2: cur_addr <= rx_st_data; // the address dword.
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            req_valid <= 1'b0;
        end else if (req_load) begin
            req_valid <= 1'b1;
        end else if (req_ready) begin
            req_valid <= 1'b0;
        end
    end

    // the output register only loads when it is empty or being taken this cycle.
    always_ff @(posedge clk) begin
        if (req_load) begin
            req_write        <= cur_write;
            req_bar0         <= cur_bar0;
            req_addr         <= cur_write ? cur_addr : rx_st_data; // a read ends on dw2.
            req_first_be     <= cur_first_be;
            req_wdata        <= rx_st_data; // only meaningful for a write.
            req_requester_id <= cur_requester_id;
            req_tag          <= cur_tag;
        end
    end

endmodule

`default_nettype wire

// File: hdl/pcie_core_pkg.sv
`default_nettype none

package pcie_core_pkg;

    // fmt/type codes as they sit in dw0 bits 30:24, fmt[1:0] followed by type[4:0].
    localparam logic [6:0] TLP_MRD32 = 7'b00_00000; // memory read with a 3-dword header.
    localparam logic [6:0] TLP_MWR32 = 7'b10_00000; // memory write with a 3-dword header.
    localparam logic [6:0] TLP_CPL   = 7'b00_01010; // completion without data.
    localparam logic [6:0] TLP_CPLD  = 7'b10_01010; // completion with data.

    // completion status field of dw1.
    localparam logic [2:0] CPL_SC = 3'b000; // successful completion.
    localparam logic [2:0] CPL_UR = 3'b001; // unsupported request.

    // on this tl_cfg_add index the low 13 bits of tl_cfg_ctl hold {bus, device}.
    localparam logic [4:0] CFG_ADDR_BUSDEV = 5'h0f;

    // dw1 of a 3-dword header reads differently for requests and completions.
    typedef union packed {
        struct packed {
            logic [15:0] requester_id; // bus, device and function of the requester.
            logic [7:0]  tag;          // returned unchanged in the completion.
            logic [3:0]  last_be;      // zero for single-dword requests.
            logic [3:0]  first_be;     // byte enables of the first dword.
        } req;
        struct packed {
            logic [15:0] completer_id; // our own bus, device and function.
            logic [2:0]  status;       // one of the CPL_* codes.
            logic        bcm;          // byte count modified, only used by bridges.
            logic [11:0] byte_count;   // remaining bytes including this completion.
        } cpl;
    } tlp_dw1_u;

endpackage

`default_nettype wire
